//--- src/blkdev_consts.svh
`ifndef BLKDEV_CONSTS_SVH
`define BLKDEV_CONSTS_SVH

// Host drives seen by the disk service
// Drive 0 is the SD card and the rest are floppies
`define BLK_NUM_VD 7

// Floppy drives handled by the per-drive ports
`define BLK_NUM_FDD 6

// Host index of floppy drive 0
`define BLK_FDD_BASE 1

// Width of the host buffer address bus
`define BLK_BUFF_AW 14

// Image size bits kept per floppy
// Larger images do not fit on a floppy anyway
`define BLK_IMG_SIZE_W 24

`endif

//--- src/blkdev_pkg.sv
`default_nettype none

`include "blkdev_consts.svh"

package blkdev_pkg;

    // One sector request as raised by a core and forwarded to the host
    // Exactly one of rd and wr is set while the request is live
    typedef struct packed {
        logic [31:0] lba;
        logic [5:0]  blk_cnt;
        logic        rd;
        logic        wr;
    } blk_req_t;

    // Image state kept per floppy drive
    // Mounted stays set once the host has announced an image
    typedef struct packed {
        logic [`BLK_IMG_SIZE_W-1:0] size;
        logic                       readonly;
        logic                       mounted;
    } img_info_t;

    // One transfer on the shared host buffer bus
    // The host presents addr for both directions
    // On a read the byte comes with wr set
    typedef struct packed {
        logic [`BLK_BUFF_AW-1:0] addr;
        logic [7:0]              data;
        logic                    wr;
    } buff_beat_t;

    // Mount announcement from the host
    // Which drive it concerns travels on the separate mounted pulse vector
    typedef struct packed {
        logic [63:0] size;
        logic        readonly;
    } img_event_t;

endpackage

`default_nettype wire

//--- src/img_mount_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "blkdev_consts.svh"

// Keeps the last announced image for every floppy drive
// The host only pulses img_mounted for one cycle so the data has to be held here
module img_mount_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`BLK_NUM_VD-1:0] img_mounted,
    input  blkdev_pkg::img_event_t img_event,
    output blkdev_pkg::img_info_t  img_info [`BLK_NUM_FDD]
);

    import blkdev_pkg::*;

    // Stored image state, one entry per floppy
    img_info_t info_q [`BLK_NUM_FDD];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Nothing is mounted and every size reads zero after reset
            for (int i = 0; i < `BLK_NUM_FDD; i++) begin
                info_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `BLK_NUM_FDD; i++) begin
                // Host drive numbers are offset by the SD card slot
                if (img_mounted[`BLK_FDD_BASE + i]) begin
                    // Only the low size bits are kept
                    info_q[i].size     <= img_event.size[`BLK_IMG_SIZE_W-1:0];
                    info_q[i].readonly <= img_event.readonly;
                    // Sticky until reset, a new mount only refreshes size and readonly
                    info_q[i].mounted  <= 1'b1;
                end
            end
        end
    end

    // The registered state goes straight to the ports
    always_comb begin
        for (int i = 0; i < `BLK_NUM_FDD; i++) begin
            img_info[i] = info_q[i];
        end
    end

    // The host announces one image at a time
    // Two pulses in one cycle would share a single img_event
    mount_one_at_a_time: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(img_mounted)
    ) else $error("img_mount_tracker: more than one mount pulse in a cycle");

endmodule

`default_nettype wire

//--- src/fdd_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "blkdev_consts.svh"

// One floppy drive port between a floppy core and the host disk service
// It registers the core request toward the host and gates the host side with enable
module fdd_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  blkdev_pkg::blk_req_t   core_req,
    output logic                   core_ack,
    output blkdev_pkg::buff_beat_t core_beat,
    input  logic [7:0]             core_buff_din,
    input  blkdev_pkg::img_info_t  info_in,
    output blkdev_pkg::img_info_t  core_info,
    output blkdev_pkg::blk_req_t   host_req,
    input  logic                   host_ack,
    input  blkdev_pkg::buff_beat_t host_beat,
    output logic [7:0]             host_buff_din
);

    import blkdev_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_PENDING
    } state_t;

    state_t   state;
    blk_req_t req_q;
    logic     core_valid;
    logic     host_released;

    // The core asks for a transfer with either strobe
    assign core_valid = core_req.rd | core_req.wr;

    // Both strobes low while pending means the host has taken the request
    assign host_released = ~(req_q.rd | req_q.wr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            req_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // A disabled drive never passes a request on
                    if (enable && core_valid) begin
                        req_q <= core_req;
                        state <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    if (host_ack) begin
                        // The host has seen the request so the strobes go low
                        // on the next edge, LBA and count are kept for debug
                        req_q.rd <= 1'b0;
                        req_q.wr <= 1'b0;
                    end else if (host_released) begin
                        // Ack has fallen after the transfer
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign host_req = req_q;

    // Write data from the core is offered to the host as is
    // The drain only picks it up while this drive is acknowledged
    assign host_buff_din = core_buff_din;

    // Ack and buffer writes reach the core only on an enabled drive
    assign core_ack = enable & host_ack;

    always_comb begin
        core_beat      = host_beat;
        core_beat.wr   = enable & host_beat.wr;
    end

    // A disabled drive looks like an empty slot to the core
    always_comb begin
        core_info      = info_in;
        core_info.size = enable ? info_in.size : '0;
    end

    // The core never asks for a read and a write at once
    req_not_rd_and_wr: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(core_req.rd && core_req.wr)
    ) else $error("fdd_port: core raised rd and wr together");

    // A request waiting for ack must not change under the port
    req_stable_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        (core_valid && !core_ack) |=> $stable(core_req)
    ) else $error("fdd_port: core request changed before ack");

endmodule

`default_nettype wire

//--- src/host_side_drain.sv
`timescale 1ns/1ps
`default_nettype none

`include "blkdev_consts.svh"

// Collects the SD and floppy requests into the host's per-drive vectors
// and picks the buffer byte of the acknowledged drive
module host_side_drain (
    input  blkdev_pkg::blk_req_t   port_req      [`BLK_NUM_FDD],
    input  logic [7:0]             port_buff_din [`BLK_NUM_FDD],
    input  blkdev_pkg::blk_req_t   sd_req,
    input  logic [7:0]             sd_buff_din,
    input  logic [`BLK_NUM_VD-1:0] host_ack,
    output blkdev_pkg::blk_req_t   host_req      [`BLK_NUM_VD],
    output logic [7:0]             host_buff_din
);

    // Buffer bytes of all drives in host order
    logic [7:0] din_all [`BLK_NUM_VD];

    // SD card sits in slot 0
    // The floppies follow from BLK_FDD_BASE on
    always_comb begin
        host_req[0] = sd_req;
        for (int i = 0; i < `BLK_NUM_FDD; i++) begin
            host_req[`BLK_FDD_BASE + i] = port_req[i];
        end
    end

    always_comb begin
        din_all[0] = sd_buff_din;
        for (int i = 0; i < `BLK_NUM_FDD; i++) begin
            din_all[`BLK_FDD_BASE + i] = port_buff_din[i];
        end
    end

    // The host reads from whichever drive it is serving
    // With no ack the bus rests at zero
    always_comb begin
        host_buff_din = 8'h00;
        for (int d = 0; d < `BLK_NUM_VD; d++) begin
            if (host_ack[d]) begin
                host_buff_din = din_all[d];
            end
        end
    end

    // The host serves one drive at a time
    // With two acks the byte above would come from the higher drive only
    ack_one_at_a_time: assert final ($isunknown(host_ack) || $onehot0(host_ack))
        else $error("host_side_drain: host acknowledged more than one drive");

endmodule

`default_nettype wire

//--- src/blkdev_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "blkdev_consts.svh"

// Block device hub between the host disk service and the machine's cores
// Host drive 0 is the SD card, drives 1 to 6 are floppies behind their own ports
module blkdev_mux (
    input  logic                    clk,
    input  logic                    rst_n,
    // Machine configuration
    input  logic [`BLK_NUM_FDD-1:0] fdd_enable,
    // Host side
    output blkdev_pkg::blk_req_t    host_req [`BLK_NUM_VD],
    input  logic [`BLK_NUM_VD-1:0]  host_ack,
    input  blkdev_pkg::buff_beat_t  host_beat,
    output logic [7:0]              host_buff_din,
    input  logic [`BLK_NUM_VD-1:0]  img_mounted,
    input  blkdev_pkg::img_event_t  img_event,
    // SD card core
    input  blkdev_pkg::blk_req_t    sd_req,
    input  logic [7:0]              sd_buff_din,
    output logic                    sd_ack,
    output blkdev_pkg::buff_beat_t  sd_beat,
    output logic                    sd_img_mounted,
    output blkdev_pkg::img_event_t  sd_img_event,
    // Floppy cores
    input  blkdev_pkg::blk_req_t    fdd_req      [`BLK_NUM_FDD],
    input  logic [7:0]              fdd_buff_din [`BLK_NUM_FDD],
    output logic [`BLK_NUM_FDD-1:0] fdd_ack,
    output blkdev_pkg::buff_beat_t  fdd_beat     [`BLK_NUM_FDD],
    output blkdev_pkg::img_info_t   fdd_info     [`BLK_NUM_FDD]
);

    import blkdev_pkg::*;

    img_info_t  mount_info [`BLK_NUM_FDD];
    blk_req_t   port_req   [`BLK_NUM_FDD];
    logic [7:0] port_din   [`BLK_NUM_FDD];

    // Latches the announced image of every floppy
    img_mount_tracker u_img_mount_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .img_mounted (img_mounted),
        .img_event   (img_event),
        .img_info    (mount_info)
    );

    for (genvar g = 0; g < `BLK_NUM_FDD; g++) begin : g_fdd
        // Each port sees only its own host ack bit
        fdd_port u_fdd_port (
            .clk           (clk),
            .rst_n         (rst_n),
            .enable        (fdd_enable[g]),
            .core_req      (fdd_req[g]),
            .core_ack      (fdd_ack[g]),
            .core_beat     (fdd_beat[g]),
            .core_buff_din (fdd_buff_din[g]),
            .info_in       (mount_info[g]),
            .core_info     (fdd_info[g]),
            .host_req      (port_req[g]),
            .host_ack      (host_ack[`BLK_FDD_BASE + g]),
            .host_beat     (host_beat),
            .host_buff_din (port_din[g])
        );

        // A mount pulse has to show up at the core one edge later
        // whatever the drive's enable says
        mount_reaches_core: assert property (
            @(posedge clk) disable iff (!rst_n)
            img_mounted[`BLK_FDD_BASE + g] |=> fdd_info[g].mounted
        ) else $error("blkdev_mux: mount of floppy %0d not visible at the core", g);
    end

    // Puts every request on its host slot and returns the served drive's byte
    host_side_drain u_host_side_drain (
        .port_req      (port_req),
        .port_buff_din (port_din),
        .sd_req        (sd_req),
        .sd_buff_din   (sd_buff_din),
        .host_ack      (host_ack),
        .host_req      (host_req),
        .host_buff_din (host_buff_din)
    );

    // SD card is passed straight through and ignores fdd_enable
    assign sd_ack         = host_ack[0];
    assign sd_beat        = host_beat;
    assign sd_img_mounted = img_mounted[0];
    assign sd_img_event   = img_event;

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Clock and reset for the testbench
module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock that starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset covers the first rising edges and is released on a falling edge
    // so it never moves in the same step as the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_blkdev_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "blkdev_consts.svh"

// Table driven testbench acting as both the host disk service and the cores
module tb_blkdev_mux;

    import blkdev_pkg::*;

    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 20;

    localparam logic [2:0] OP_MOUNT   = 3'd0;
    localparam logic [2:0] OP_REQUEST = 3'd1;
    localparam logic [2:0] OP_BUFFER  = 3'd2;
    localparam logic [2:0] OP_CONFIG  = 3'd3;
    localparam logic [2:0] OP_SD      = 3'd4;

    // One table row with drv as the host drive number
    typedef struct packed {
        logic [2:0]              op;
        logic [2:0]              drv;
        logic                    rd;
        logic                    ro;
        logic [`BLK_NUM_FDD-1:0] en;
        logic [63:0]             size;
    } entry_t;

    logic                    clk;
    logic                    rst_n;
    logic [`BLK_NUM_FDD-1:0] fdd_enable;
    blk_req_t                host_req [`BLK_NUM_VD];
    logic [`BLK_NUM_VD-1:0]  host_ack;
    buff_beat_t              host_beat;
    logic [7:0]              host_buff_din;
    logic [`BLK_NUM_VD-1:0]  img_mounted;
    img_event_t              img_event;
    blk_req_t                sd_req;
    logic [7:0]              sd_buff_din;
    logic                    sd_ack;
    buff_beat_t              sd_beat;
    logic                    sd_img_mounted;
    img_event_t              sd_img_event;
    blk_req_t                fdd_req      [`BLK_NUM_FDD];
    logic [7:0]              fdd_buff_din [`BLK_NUM_FDD];
    logic [`BLK_NUM_FDD-1:0] fdd_ack;
    buff_beat_t              fdd_beat     [`BLK_NUM_FDD];
    img_info_t               fdd_info     [`BLK_NUM_FDD];

    string     names [$];
    entry_t    table_q [$];
    // Image state every floppy should hold according to the mount rules
    img_info_t exp_info [`BLK_NUM_FDD];
    integer    seed;
    string     cur_name;
    int        test_errs;
    int        err_total;
    int        n_tests;
    int        n_failed;
    bit        timed_out;

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(3)) u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    blkdev_mux u_blkdev_mux (
        .clk(clk), .rst_n(rst_n), .fdd_enable(fdd_enable),
        .host_req(host_req), .host_ack(host_ack), .host_beat(host_beat),
        .host_buff_din(host_buff_din), .img_mounted(img_mounted), .img_event(img_event),
        .sd_req(sd_req), .sd_buff_din(sd_buff_din), .sd_ack(sd_ack), .sd_beat(sd_beat),
        .sd_img_mounted(sd_img_mounted), .sd_img_event(sd_img_event),
        .fdd_req(fdd_req), .fdd_buff_din(fdd_buff_din), .fdd_ack(fdd_ack),
        .fdd_beat(fdd_beat), .fdd_info(fdd_info)
    );

    // Inputs always change a little after the rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic add_entry(input string name, input logic [2:0] op, input int drv,
                             input bit rd, input bit ro, input logic [5:0] en,
                             input logic [63:0] size);
        entry_t e;
        e.op   = op;
        e.drv  = drv[2:0];
        e.rd   = rd;
        e.ro   = ro;
        e.en   = en;
        e.size = size;
        names.push_back(name);
        table_q.push_back(e);
    endtask

    task automatic report_err();
        test_errs++;
        err_total++;
    endtask

    task automatic check_req(input string what, input blk_req_t exp, input blk_req_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_info(input string what, input img_info_t exp, input img_info_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_beat(input string what, input buff_beat_t exp, input buff_beat_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_event(input string what, input img_event_t exp, input img_event_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b actual %b", cur_name, what, exp, act);
            report_err();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s %s: expected %0d actual %0d", cur_name, what, exp, act);
            report_err();
        end
    endtask

    // A disabled drive shows its image with the size forced to zero
    function automatic img_info_t visible_info(input int f);
        img_info_t v;
        v = exp_info[f];
        if (!fdd_enable[f]) begin
            v.size = '0;
        end
        return v;
    endfunction

    task automatic check_all_info();
        for (int f = 0; f < `BLK_NUM_FDD; f++) begin
            check_info($sformatf("info fdd%0d", f), visible_info(f), fdd_info[f]);
        end
    endtask

    function automatic blk_req_t rand_req(input bit rd);
        blk_req_t r;
        int       tmp;
        r.lba     = $random(seed);
        tmp       = $random(seed);
        r.blk_cnt = tmp[5:0];
        r.rd      = rd;
        r.wr      = ~rd;
        return r;
    endfunction

    function automatic buff_beat_t rand_beat();
        buff_beat_t b;
        int         tmp;
        tmp    = $random(seed);
        b.addr = tmp[`BLK_BUFF_AW-1:0];
        b.data = tmp[23:16];
        b.wr   = 1'b1;
        return b;
    endfunction

    function automatic logic [7:0] rand_byte();
        int tmp;
        tmp = $random(seed);
        return tmp[7:0];
    endfunction

    // Host side of one transfer on an enabled floppy whose core already holds req
    task automatic serve_request(input int f, input blk_req_t req);
        int         d;
        int         cycles;
        logic [7:0] din;
        buff_beat_t beat;
        blk_req_t   done_req;
        d      = `BLK_FDD_BASE + f;
        cycles = 0;
        while (!(host_req[d].rd || host_req[d].wr) && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!(host_req[d].rd || host_req[d].wr)) begin
            $display("Timeout: request of floppy %0d never reached host drive %0d", f, d);
            timed_out = 1'b1;
            report_err();
            return;
        end
        check_count("request latency", 1, cycles);
        check_req("host request", req, host_req[d]);
        // Host acknowledges and moves one byte each way
        din             = rand_byte();
        beat            = rand_beat();
        host_ack[d]     = 1'b1;
        host_beat       = beat;
        fdd_buff_din[f] = din;
        #1;
        check_flag("core ack", 1'b1, fdd_ack[f]);
        check_beat("core beat", beat, fdd_beat[f]);
        check_byte("host buff_din", din, host_buff_din);
        // Ack has been sampled so the strobes toward the host are gone
        step();
        fdd_req[f]   = '0;
        host_beat.wr = 1'b0;
        done_req     = req;
        done_req.rd  = 1'b0;
        done_req.wr  = 1'b0;
        check_req("host request after ack", done_req, host_req[d]);
        step();
        host_ack[d] = 1'b0;
        #1;
        check_flag("core ack after transfer", 1'b0, fdd_ack[f]);
        check_byte("host buff_din without ack", 8'h00, host_buff_din);
        step();
    endtask

    // The request must wait unseen until the drive gets enabled
    task automatic disabled_request(input int f, input blk_req_t req);
        int         d;
        buff_beat_t beat;
        buff_beat_t masked;
        d = `BLK_FDD_BASE + f;
        repeat (3) begin
            step();
            check_flag("host strobe of disabled drive", 1'b0, host_req[d].rd | host_req[d].wr);
        end
        beat      = rand_beat();
        masked    = beat;
        masked.wr = 1'b0;
        // Even a stray host ack must not leak through
        host_ack[d] = 1'b1;
        host_beat   = beat;
        #1;
        check_flag("ack of disabled drive", 1'b0, fdd_ack[f]);
        check_beat("beat of disabled drive", masked, fdd_beat[f]);
        check_info("info of disabled drive", visible_info(f), fdd_info[f]);
        step();
        host_ack[d]   = 1'b0;
        host_beat.wr  = 1'b0;
        fdd_enable[f] = 1'b1;
        serve_request(f, req);
        if (!timed_out) begin
            fdd_enable[f] = 1'b0;
        end
    endtask

    task automatic mount_image(input entry_t e);
        int f;
        f = e.drv - `BLK_FDD_BASE;
        step();
        img_event.size     = e.size;
        img_event.readonly = e.ro;
        img_mounted        = '0;
        img_mounted[e.drv] = 1'b1;
        #1;
        // Nothing changes before the edge that takes the pulse
        check_all_info();
        exp_info[f].size     = e.size[`BLK_IMG_SIZE_W-1:0];
        exp_info[f].readonly = e.ro;
        exp_info[f].mounted  = 1'b1;
        step();
        img_mounted = '0;
        #1;
        check_all_info();
    endtask

    // Beats without any ack reach every core but write only on enabled drives
    task automatic buffer_beats();
        buff_beat_t beat;
        buff_beat_t masked;
        beat = rand_beat();
        step();
        host_beat = beat;
        for (int f = 0; f < `BLK_NUM_FDD; f++) begin
            fdd_buff_din[f] = rand_byte();
        end
        sd_buff_din = rand_byte();
        #1;
        for (int f = 0; f < `BLK_NUM_FDD; f++) begin
            masked    = beat;
            masked.wr = fdd_enable[f];
            check_beat($sformatf("beat fdd%0d", f), masked, fdd_beat[f]);
        end
        check_beat("sd beat", beat, sd_beat);
        check_byte("host buff_din without ack", 8'h00, host_buff_din);
        step();
        host_beat.wr = 1'b0;
    endtask

    task automatic sd_passthrough();
        blk_req_t   req;
        buff_beat_t beat;
        img_event_t ev;
        logic [7:0] din;
        req              = rand_req(1'b0);
        beat             = rand_beat();
        din              = rand_byte();
        ev.size[63:32]   = $random(seed);
        ev.size[31:0]    = $random(seed);
        ev.readonly      = 1'b1;
        step();
        // Request, ack, beat and mount announcement of drive 0 go out together
        sd_req         = req;
        host_ack[0]    = 1'b1;
        host_beat      = beat;
        sd_buff_din    = din;
        img_mounted[0] = 1'b1;
        img_event      = ev;
        #1;
        check_req("sd host request", req, host_req[0]);
        check_flag("sd ack", 1'b1, sd_ack);
        check_beat("sd beat", beat, sd_beat);
        check_byte("host buff_din", din, host_buff_din);
        check_flag("sd mounted pulse", 1'b1, sd_img_mounted);
        check_event("sd image event", ev, sd_img_event);
        check_count("floppy acks", 0, fdd_ack);
        step();
        sd_req      = '0;
        host_ack    = '0;
        host_beat   = '0;
        img_mounted = '0;
        #1;
        // The tracker keeps drive 0 out of the floppy state
        check_all_info();
    endtask

    initial begin
        entry_t e;
        int     n;
        seed        = 32'hf714_96df;
        fdd_enable  = '0;
        host_ack    = '0;
        host_beat   = '0;
        img_mounted = '0;
        img_event   = '0;
        sd_req      = '0;
        sd_buff_din = '0;
        for (int f = 0; f < `BLK_NUM_FDD; f++) begin
            fdd_req[f]      = '0;
            fdd_buff_din[f] = '0;
            exp_info[f]     = '0;
        end
        add_entry("mount_fdd0",         OP_MOUNT,   1, 0, 0, 6'h00, 64'h0000_0001_0016_8000);
        add_entry("mount_fdd3_ro",      OP_MOUNT,   4, 0, 1, 6'h00, 64'h0000_0000_000b_4000);
        add_entry("mount_fdd1",         OP_MOUNT,   2, 0, 0, 6'h00, 64'h0000_0000_0005_a000);
        add_entry("cfg_fdd0_fdd3_on",   OP_CONFIG,  0, 0, 0, 6'h09, 64'h0);
        add_entry("read_fdd0",          OP_REQUEST, 1, 1, 0, 6'h00, 64'h0);
        add_entry("write_fdd3",         OP_REQUEST, 4, 0, 0, 6'h00, 64'h0);
        add_entry("beats_no_ack",       OP_BUFFER,  0, 0, 0, 6'h00, 64'h0);
        add_entry("read_fdd1_disabled", OP_REQUEST, 2, 1, 0, 6'h00, 64'h0);
        add_entry("remount_fdd0_ro",    OP_MOUNT,   1, 0, 1, 6'h00, 64'hffff_0000_002d_0000);
        add_entry("cfg_all_off",        OP_CONFIG,  0, 0, 0, 6'h00, 64'h0);
        add_entry("sd_passthrough",     OP_SD,      0, 0, 0, 6'h00, 64'h0);
        add_entry("cfg_all_on",         OP_CONFIG,  0, 0, 0, 6'h3f, 64'h0);
        add_entry("sd_fdd_all_on",      OP_SD,      0, 0, 0, 6'h00, 64'h0);
        add_entry("read_fdd5",          OP_REQUEST, 6, 1, 0, 6'h00, 64'h0);
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            cur_name  = "reset_state";
            test_errs = 0;
            for (int d = 0; d < `BLK_NUM_VD; d++) begin
                check_req($sformatf("host request %0d", d), '0, host_req[d]);
            end
            check_all_info();
            n_tests++;
            n_failed += (test_errs != 0);
            $display("test %s: %s", cur_name, (test_errs == 0) ? "ok" : "failed");
        end
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            e         = table_q[i];
            cur_name  = names[i];
            test_errs = 0;
            case (e.op)
                OP_MOUNT: mount_image(e);
                OP_BUFFER: buffer_beats();
                OP_SD: sd_passthrough();
                OP_CONFIG: begin
                    step();
                    fdd_enable = e.en;
                    #1;
                    check_all_info();
                end
                default: begin
                    n = e.drv - `BLK_FDD_BASE;
                    step();
                    fdd_req[n] = rand_req(e.rd);
                    if (fdd_enable[n]) begin
                        serve_request(n, fdd_req[n]);
                    end else begin
                        disabled_request(n, fdd_req[n]);
                    end
                end
            endcase
            n_tests++;
            n_failed += (test_errs != 0);
            $display("test %s: %s (%0d errors)", cur_name,
                     (test_errs == 0) ? "ok" : "failed", test_errs);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 n_tests, n_failed, err_total);
        if (err_total == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/blkdev_pkg.sv
src/img_mount_tracker.sv
src/fdd_port.sv
src/host_side_drain.sv
src/blkdev_mux.sv
tests/tb_clk_gen.sv
tests/tb_blkdev_mux.sv

//--- Bender.yml
package:
  name: blkdev_mux

export_include_dirs:
  - src

sources:
  # Synthesizable design
  - include_dirs:
      - src
    files:
      - src/blkdev_pkg.sv
      - src/img_mount_tracker.sv
      - src/fdd_port.sv
      - src/host_side_drain.sv
      - src/blkdev_mux.sv

  # Simulation only
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_blkdev_mux.sv
